// File: build.f
+incdir+test
hdl/ctrl_pkg.sv
hdl/reg_match_if.sv
hdl/ctrl_fsm.sv
hdl/hazard_unit.sv
hdl/fwd_unit.sv
hdl/ctrl_top.sv
test/tb_ctrl.sv

// File: hdl/ctrl_fsm.sv
// decoder request inputs must stay stable while the flush runs since FLUSH_WB reads them again
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_taken_ex_i,

  // decoder requests
  input  logic                 mret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 int_req_i,
  input  logic                 ext_req_i,

  // stage status
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 jr_stall_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,

  output logic                 ctrl_busy_o,
  output logic                 first_fetch_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 irq_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once a jump has requested its pc, cleared when ID moves on
  logic jump_done_q;
  logic jump_done_d;

  logic jump_in_dec;
  logic flush_req;

  // jal and jalr know their target in decode
  assign jump_in_dec = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  // anything that needs the pipeline drained before acting
  assign flush_req = ext_req_i | int_req_i | mret_insn_i | pipe_flush_i;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb
  begin
    // busy and fetching unless a state says otherwise
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    first_fetch_o    = 1'b0;
    is_decoding_o    = 1'b0;

    pc_set_o         = 1'b0;
    pc_mux_o         = PC_BOOT;

    exc_ack_o        = 1'b0;
    irq_ack_o        = 1'b0;
    exc_save_if_o    = 1'b0;
    exc_save_id_o    = 1'b0;
    exc_restore_id_o = 1'b0;

    halt_if_o        = 1'b0;
    halt_id_o        = 1'b0;

    jump_done_d      = jump_done_q;
    state_d          = state_q;

    case (state_q)
      // idle after reset until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch pc
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          state_d = DECODE;
        // pipeline is empty here so an interrupt is taken right away
        if (ext_req_i)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN_FIRSTFETCH;
        end
      end

      DECODE:
      begin
        // the ID instruction only counts if no branch in EX kills it
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;
          if (flush_req)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
          else if (jump_in_dec)
          begin
            pc_mux_o = PC_JUMP;
            // one pc set per jump, held off by a jr hazard
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
        end
        // taken branch in EX redirects fetch this cycle
        if (branch_taken_ex_i)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_BRANCH;
        end
      end

      // drain EX, nothing new enters
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = ext_req_i ? IRQ_TAKEN : FLUSH_WB;
      end

      // EX and WB are empty, act on the request held in ID
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (int_req_i)
        begin
          // ecall or illegal instruction
          pc_set_o      = 1'b1;
          pc_mux_o      = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
          exc_save_id_o = 1'b1;
        end
        else if (mret_insn_i)
        begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_ERET;
          exc_restore_id_o = 1'b1;
        end
        // wfi with fetch disabled goes to sleep
        state_d = fetch_enable_i ? DECODE : WAIT_SLEEP;
      end

      // interrupt entry, pc of the ID instruction is saved
      IRQ_TAKEN:
      begin
        pc_set_o      = 1'b1;
        pc_mux_o      = PC_EXCEPTION;
        exc_ack_o     = 1'b1;
        irq_ack_o     = 1'b1;
        exc_save_id_o = 1'b1;
        state_d       = DECODE;
      end

      // interrupt entry from first fetch, pc of the IF instruction is saved
      IRQ_TAKEN_FIRSTFETCH:
      begin
        pc_set_o      = 1'b1;
        pc_mux_o      = PC_EXCEPTION;
        exc_ack_o     = 1'b1;
        irq_ack_o     = 1'b1;
        exc_save_if_o = 1'b1;
        state_d       = DECODE;
      end

      // one idle cycle before sleeping
      WAIT_SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // wake on fetch enable or external interrupt
      SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || ext_req_i)
          state_d = FIRST_FETCH;
      end

      // unused encodings fall back to reset
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state and jump-done registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // done flag survives only while ID is stalled
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

// File: hdl/ctrl_pkg.sv
// pc mux and forwarding encodings are fixed by the IF and ID stage muxes and must not be reordered
package ctrl_pkg;

  ////////////////////////////////////////
  // fetch stage pc source
  ////////////////////////////////////////

  // 3'b001 and 3'b111 are left free for fence.i and debug in a fuller core
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // operand source seen by the ID stage operand muxes
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // jump class as produced by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  ////////////////////////////////////////
  // controller states
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    RESET, BOOT_SET, FIRST_FETCH, DECODE,
    FLUSH_EX, FLUSH_WB,
    IRQ_TAKEN, IRQ_TAKEN_FIRSTFETCH,
    WAIT_SLEEP, SLEEP
  } ctrl_state_e;

endpackage

// File: hdl/ctrl_top.sv
// all inputs are pipeline levels sampled on clk and no bus handshake is involved
`timescale 1ns/1ps

module ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 fetch_enable_i,
  input  logic                 illegal_insn_i,
  input  logic                 mret_insn_i,
  input  logic                 pipe_flush_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_taken_ex_i,
  input  logic                 int_req_i,
  input  logic                 ext_req_i,
  input  logic                 id_ready_i,
  input  logic                 ex_valid_i,
  input  logic                 data_req_ex_i,
  input  logic                 data_misaligned_i,
  input  logic                 mult_multicycle_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,

  // register file write enables and destination matches
  input  logic                 regfile_we_ex_i,
  input  logic                 regfile_we_wb_i,
  input  logic                 regfile_alu_we_fw_i,
  input  logic                 reg_d_ex_is_reg_a_i,
  input  logic                 reg_d_ex_is_reg_b_i,
  input  logic                 reg_d_ex_is_reg_c_i,
  input  logic                 reg_d_wb_is_reg_a_i,
  input  logic                 reg_d_wb_is_reg_b_i,
  input  logic                 reg_d_wb_is_reg_c_i,
  input  logic                 reg_d_alu_is_reg_a_i,
  input  logic                 reg_d_alu_is_reg_b_i,
  input  logic                 reg_d_alu_is_reg_c_i,

  output logic                 ctrl_busy_o,
  output logic                 first_fetch_o,
  output logic                 is_decoding_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output ctrl_pkg::pc_mux_e    pc_mux_o,
  output logic                 exc_ack_o,
  output logic                 irq_ack_o,
  output logic                 exc_save_if_o,
  output logic                 exc_save_id_o,
  output logic                 exc_restore_id_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 deassert_we_o,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output ctrl_pkg::fw_sel_e    operand_a_fw_sel_o,
  output ctrl_pkg::fw_sel_e    operand_b_fw_sel_o,
  output ctrl_pkg::fw_sel_e    operand_c_fw_sel_o
);

  // fsm and hazard unit talk over these two
  logic jr_stall;
  logic is_decoding;

  reg_match_if match ();

  ////////////////////////////////////////
  // fill the match bundle
  ////////////////////////////////////////

  assign match.we_ex     = regfile_we_ex_i;
  assign match.we_wb     = regfile_we_wb_i;
  assign match.alu_we_fw = regfile_alu_we_fw_i;
  assign match.ex_is_a   = reg_d_ex_is_reg_a_i;
  assign match.ex_is_b   = reg_d_ex_is_reg_b_i;
  assign match.ex_is_c   = reg_d_ex_is_reg_c_i;
  assign match.wb_is_a   = reg_d_wb_is_reg_a_i;
  assign match.wb_is_b   = reg_d_wb_is_reg_b_i;
  assign match.wb_is_c   = reg_d_wb_is_reg_c_i;
  assign match.alu_is_a  = reg_d_alu_is_reg_a_i;
  assign match.alu_is_b  = reg_d_alu_is_reg_b_i;
  assign match.alu_is_c  = reg_d_alu_is_reg_c_i;

  assign jr_stall_o    = jr_stall;
  assign is_decoding_o = is_decoding;

  ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .mret_insn_i       (mret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .int_req_i         (int_req_i),
    .ext_req_i         (ext_req_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .jr_stall_i        (jr_stall),
    .jump_in_dec_i     (jump_in_dec_i),
    .ctrl_busy_o       (ctrl_busy_o),
    .first_fetch_o     (first_fetch_o),
    .is_decoding_o     (is_decoding),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ack_o         (exc_ack_o),
    .irq_ack_o         (irq_ack_o),
    .exc_save_if_o     (exc_save_if_o),
    .exc_save_id_o     (exc_save_id_o),
    .exc_restore_id_o  (exc_restore_id_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  hazard_unit u_hazard (
    .match          (match),
    .data_req_ex_i  (data_req_ex_i),
    .illegal_insn_i (illegal_insn_i),
    .is_decoding_i  (is_decoding),
    .jump_in_dec_i  (jump_in_dec_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall),
    .deassert_we_o  (deassert_we_o)
  );

  fwd_unit u_fwd (
    .match              (match),
    .data_misaligned_i  (data_misaligned_i),
    .mult_multicycle_i  (mult_multicycle_i),
    .operand_a_fw_sel_o (operand_a_fw_sel_o),
    .operand_b_fw_sel_o (operand_b_fw_sel_o),
    .operand_c_fw_sel_o (operand_c_fw_sel_o)
  );

endmodule

// File: hdl/fwd_unit.sv
// EX forwarding has priority over WB and the misaligned override wins over the multiply one
`timescale 1ns/1ps

module fwd_unit (
  reg_match_if.consumer     match,
  input  logic              data_misaligned_i,
  input  logic              mult_multicycle_i,
  output ctrl_pkg::fw_sel_e operand_a_fw_sel_o,
  output ctrl_pkg::fw_sel_e operand_b_fw_sel_o,
  output ctrl_pkg::fw_sel_e operand_c_fw_sel_o
);

  import ctrl_pkg::*;

  // per operand source from the wb and alu hits
  function automatic fw_sel_e pick_src(input logic wb_hit, input logic alu_hit);
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    // the younger result in EX overrides WB
    if (alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  ////////////////////////////////////////
  // operand select
  ////////////////////////////////////////

  always_comb
  begin
    operand_a_fw_sel_o = pick_src(match.we_wb & match.wb_is_a, match.alu_we_fw & match.alu_is_a);
    operand_b_fw_sel_o = pick_src(match.we_wb & match.wb_is_b, match.alu_we_fw & match.alu_is_b);
    operand_c_fw_sel_o = pick_src(match.we_wb & match.wb_is_c, match.alu_we_fw & match.alu_is_c);

    // second half of a misaligned access reuses the EX address
    if (data_misaligned_i)
    begin
      operand_a_fw_sel_o = SEL_FW_EX;
      operand_b_fw_sel_o = SEL_REGFILE;
    end
    // multicycle multiply keeps its partial result on operand c
    else if (mult_multicycle_i)
    begin
      operand_c_fw_sel_o = SEL_FW_EX;
    end
  end

endmodule

// File: hdl/hazard_unit.sv
// stalls are combinational and assume match flags settle within the ID cycle
`timescale 1ns/1ps

module hazard_unit (
  reg_match_if.consumer        match,
  input  logic                 data_req_ex_i,
  input  logic                 illegal_insn_i,
  input  logic                 is_decoding_i,
  input  ctrl_pkg::jump_kind_e jump_in_dec_i,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);

  import ctrl_pkg::*;

  logic ex_hit_any;
  logic a_pending;

  // EX destination used by any operand of the ID instruction
  assign ex_hit_any = match.ex_is_a | match.ex_is_b | match.ex_is_c;

  // operand a still has a write in flight somewhere
  assign a_pending = (match.we_wb & match.wb_is_a) |
                     (match.we_ex & match.ex_is_a) |
                     (match.alu_we_fw & match.alu_is_a);

  ////////////////////////////////////////
  // stall detection
  ////////////////////////////////////////

  always_comb
  begin
    // load data arrives too late to forward to ID
    load_stall_o = data_req_ex_i & match.we_ex & ex_hit_any;

    // jalr target comes from operand a so it must be final
    jr_stall_o = (jump_in_dec_i == BRANCH_JALR) & a_pending;

    // ID instruction must not write back
    deassert_we_o = load_stall_o | jr_stall_o | illegal_insn_i | ~is_decoding_i;
  end

endmodule

// File: hdl/reg_match_if.sv
// match flags are raw register compares and only count when paired with their write enable
`timescale 1ns/1ps

interface reg_match_if;

  // write enables of every stage that can feed an operand
  logic we_ex;
  logic we_wb;
  logic alu_we_fw;

  // ex destination equals operand register a, b or c
  logic ex_is_a;
  logic ex_is_b;
  logic ex_is_c;

  // wb destination equals operand register
  logic wb_is_a;
  logic wb_is_b;
  logic wb_is_c;

  // alu forwarding path destination equals operand register
  logic alu_is_a;
  logic alu_is_b;
  logic alu_is_c;

  // hazard and forwarding units only look
  modport consumer (
    input we_ex, we_wb, alu_we_fw,
    input ex_is_a, ex_is_b, ex_is_c,
    input wb_is_a, wb_is_b, wb_is_c,
    input alu_is_a, alu_is_b, alu_is_c
  );

endinterface

// File: test/tb_ctrl_checks.svh
// included inside tb_ctrl after errors and checks exist, hazard rule assumes the FSM is in DECODE

  ////////////////////////////////////////
  // typed compares
  ////////////////////////////////////////

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pc(input string what, input pc_mux_e got, input pc_mux_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_sel(input string what, input fw_sel_e got, input fw_sel_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  // returns load stall, jr stall and write-enable drop
  function automatic logic [2:0] ref_stall(input logic [11:0] m, input logic [5:0] ctl);
    logic load;
    logic jr;
    load = ctl[4] && m[11] && (m[8:6] != 3'b000);
    // jalr waits for any pending write of operand a
    jr   = ctl[0] && ((m[10] && m[5]) || (m[11] && m[8]) || (m[9] && m[2]));
    return {load, jr, load || jr || ctl[3] || !ctl[5]};
  endfunction

  // source of operand k, 0 is a and 2 is c
  function automatic fw_sel_e ref_fw(input logic [11:0] m, input logic [5:0] ctl, input int k);
    if (ctl[2] && k == 0)
      return SEL_FW_EX;
    if (ctl[2] && k == 1)
      return SEL_REGFILE;
    if (!ctl[2] && ctl[1] && k == 2)
      return SEL_FW_EX;
    if (m[9] && m[2 - k])
      return SEL_FW_EX;
    if (m[10] && m[5 - k])
      return SEL_FW_WB;
    return SEL_REGFILE;
  endfunction

// File: test/tb_ctrl.sv
// hazard and forwarding rows run with the FSM parked in DECODE, fetch enabled and ID ready
`timescale 1ns/1ps

module tb_ctrl;

  import ctrl_pkg::*;

  // stim is fe iv br int ext mret flush rdy exv wb_a
  // exp is pc_set busy ff dec halt exc_ack irq_ack save_if save_id restore
  typedef struct packed {
    logic [9:0] stim;
    logic [1:0] jump;
    logic [9:0] exp;
    logic [2:0] mux;
  } fsm_row_t;

  // m is we_ex we_wb alu_we, ex_abc, wb_abc, alu_abc
  // ctl is iv dreq illegal misaligned mult jalr
  typedef struct packed {
    logic [11:0] m;
    logic [5:0]  ctl;
    logic [2:0]  st;
    logic [1:0]  fa;
    logic [1:0]  fb;
    logic [1:0]  fc;
  } comb_row_t;

  logic        clk;
  logic        rst_n;
  logic [9:0]  stim;
  logic [11:0] m_in;
  // dreq illegal misaligned mult
  logic [3:0]  side;
  jump_kind_e  jump_in_dec;

  logic ctrl_busy_o, first_fetch_o, is_decoding_o, instr_req_o, pc_set_o;
  logic exc_ack_o, irq_ack_o, exc_save_if_o, exc_save_id_o, exc_restore_id_o;
  logic halt_if_o, halt_id_o, deassert_we_o, load_stall_o, jr_stall_o;
  pc_mux_e pc_mux_o;
  fw_sel_e operand_a_fw_sel_o, operand_b_fw_sel_o, operand_c_fw_sel_o;

  int     errors;
  int     checks;
  int     total_rows;
  integer seed;

  fsm_row_t  fsm_q[$];
  comb_row_t comb_q[$];
  string     fsm_names[$];
  int        fsm_cuts[$];
  string     comb_names[$];
  int        comb_cuts[$];

  `include "tb_ctrl_checks.svh"

  ctrl_top DUT (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (stim[9]), .instr_valid_i (stim[8]), .branch_taken_ex_i (stim[7]),
    .int_req_i (stim[6]), .ext_req_i (stim[5]), .mret_insn_i (stim[4]),
    .pipe_flush_i (stim[3]), .id_ready_i (stim[2]), .ex_valid_i (stim[1]),
    .illegal_insn_i (side[2]), .data_req_ex_i (side[3]),
    .data_misaligned_i (side[1]), .mult_multicycle_i (side[0]),
    .jump_in_dec_i (jump_in_dec),
    .regfile_we_ex_i (m_in[11]), .regfile_we_wb_i (m_in[10]), .regfile_alu_we_fw_i (m_in[9]),
    .reg_d_ex_is_reg_a_i (m_in[8]), .reg_d_ex_is_reg_b_i (m_in[7]),
    .reg_d_ex_is_reg_c_i (m_in[6]), .reg_d_wb_is_reg_a_i (m_in[5]),
    .reg_d_wb_is_reg_b_i (m_in[4]), .reg_d_wb_is_reg_c_i (m_in[3]),
    .reg_d_alu_is_reg_a_i (m_in[2]), .reg_d_alu_is_reg_b_i (m_in[1]),
    .reg_d_alu_is_reg_c_i (m_in[0]),
    .ctrl_busy_o (ctrl_busy_o), .first_fetch_o (first_fetch_o),
    .is_decoding_o (is_decoding_o), .instr_req_o (instr_req_o),
    .pc_set_o (pc_set_o), .pc_mux_o (pc_mux_o),
    .exc_ack_o (exc_ack_o), .irq_ack_o (irq_ack_o),
    .exc_save_if_o (exc_save_if_o), .exc_save_id_o (exc_save_id_o),
    .exc_restore_id_o (exc_restore_id_o),
    .halt_if_o (halt_if_o), .halt_id_o (halt_id_o),
    .deassert_we_o (deassert_we_o), .load_stall_o (load_stall_o), .jr_stall_o (jr_stall_o),
    .operand_a_fw_sel_o (operand_a_fw_sel_o), .operand_b_fw_sel_o (operand_b_fw_sel_o),
    .operand_c_fw_sel_o (operand_c_fw_sel_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // table building
  ////////////////////////////////////////

  task automatic add_fsm(input logic [9:0] s, input jump_kind_e jk, input logic [9:0] e,
                         input pc_mux_e mux);
    fsm_row_t r;
    r.stim = s;
    r.jump = jk;
    r.exp  = e;
    r.mux  = mux;
    fsm_q.push_back(r);
  endtask

  task automatic add_comb(input logic [11:0] m, input logic [5:0] ctl, input logic [2:0] st,
                          input fw_sel_e fa, input fw_sel_e fb, input fw_sel_e fc);
    comb_row_t r;
    r.m   = m;
    r.ctl = ctl;
    r.st  = st;
    r.fa  = fa;
    r.fb  = fb;
    r.fc  = fc;
    comb_q.push_back(r);
  endtask

  // expected values come from the reference rules
  task automatic add_random(input int n);
    logic [11:0] m;
    logic [5:0]  ctl;
    repeat (n)
    begin
      m   = 12'($random(seed));
      ctl = 6'($random(seed));
      add_comb(m, ctl, ref_stall(m, ctl),
               ref_fw(m, ctl, 0), ref_fw(m, ctl, 1), ref_fw(m, ctl, 2));
    end
  endtask

  task automatic close_fsm(input string name);
    fsm_names.push_back(name);
    fsm_cuts.push_back(fsm_q.size());
  endtask

  task automatic close_comb(input string name);
    comb_names.push_back(name);
    comb_cuts.push_back(comb_q.size());
  endtask

  ////////////////////////////////////////
  // row application
  ////////////////////////////////////////

  task automatic apply_fsm(input fsm_row_t r);
    @(posedge clk);
    #1;
    stim        = r.stim;
    jump_in_dec = jump_kind_e'(r.jump);
    // wb_a column is a pending WB write to operand a
    m_in        = {1'b0, r.stim[0], 4'b0000, r.stim[0], 5'b00000};
    side        = 4'b0000;
    #8;
    check_bit("pc_set_o", pc_set_o, r.exp[9]);
    if (r.exp[9])
      check_pc("pc_mux_o", pc_mux_o, pc_mux_e'(r.mux));
    check_bit("ctrl_busy_o", ctrl_busy_o, r.exp[8]);
    check_bit("instr_req_o", instr_req_o, r.exp[8]);
    check_bit("first_fetch_o", first_fetch_o, r.exp[7]);
    check_bit("is_decoding_o", is_decoding_o, r.exp[6]);
    check_bit("halt_if_o", halt_if_o, r.exp[5]);
    check_bit("halt_id_o", halt_id_o, r.exp[5]);
    check_bit("exc_ack_o", exc_ack_o, r.exp[4]);
    check_bit("irq_ack_o", irq_ack_o, r.exp[3]);
    check_bit("exc_save_if_o", exc_save_if_o, r.exp[2]);
    check_bit("exc_save_id_o", exc_save_id_o, r.exp[1]);
    check_bit("exc_restore_id_o", exc_restore_id_o, r.exp[0]);
  endtask

  task automatic apply_comb(input comb_row_t r);
    @(posedge clk);
    #1;
    // fetch enabled, ID ready, no flush request keeps DECODE
    stim        = {1'b1, r.ctl[5], 5'b00000, 1'b1, 2'b00};
    jump_in_dec = r.ctl[0] ? BRANCH_JALR : BRANCH_NONE;
    m_in        = r.m;
    side        = r.ctl[4:1];
    #8;
    check_bit("load_stall_o", load_stall_o, r.st[2]);
    check_bit("jr_stall_o", jr_stall_o, r.st[1]);
    check_bit("deassert_we_o", deassert_we_o, r.st[0]);
    check_sel("operand_a_fw_sel_o", operand_a_fw_sel_o, fw_sel_e'(r.fa));
    check_sel("operand_b_fw_sel_o", operand_b_fw_sel_o, fw_sel_e'(r.fb));
    check_sel("operand_c_fw_sel_o", operand_c_fw_sel_o, fw_sel_e'(r.fc));
  endtask

  task automatic report(input string name, input int rows, input int errs);
    $display("test %-18s %0d rows, %0d mismatches", name, rows, errs);
  endtask

  // 40 ns per row leaves room for every wait in the tables
  initial
  begin : watchdog
    wait (total_rows > 0);
    #(total_rows * 40);
    $display("timeout: rows not finished after %0d ns", total_rows * 40);
    $display("Checks failed");
    $finish;
  end

  initial
  begin : main
    int t;
    int i;
    int first;
    int errs0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    stim        = '0;
    m_in        = '0;
    side        = '0;
    jump_in_dec = BRANCH_NONE;
    errors      = 0;
    checks      = 0;
    seed        = 25903;

    //             fe iv br int ext mret flush rdy exv wb_a   ps busy ff dec halt ack irq sif sid rst
    add_fsm(10'b0_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b0_0_0_0_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b0_0_0_0_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b1_1_0_0_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b0_1_1_0_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_0_0_0_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_1_0_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    close_fsm("reset and boot");
    // jalr held by a WB write, then one pc set while ID stays stalled
    add_fsm(10'b1_1_0_0_0_0_0_0_0_1, BRANCH_JALR, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_0_0_0_0_1, BRANCH_JALR, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_0_0_0_0_0, BRANCH_JALR, 10'b1_1_0_1_0_0_0_0_0_0, PC_JUMP);
    add_fsm(10'b1_1_0_0_0_0_0_0_0_0, BRANCH_JALR, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_0_0_1_0_0, BRANCH_JALR, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    close_fsm("jalr stall");
    add_fsm(10'b1_1_1_0_0_0_0_1_0_0, BRANCH_NONE, 10'b1_1_0_0_0_0_0_0_0_0, PC_BRANCH);
    add_fsm(10'b1_1_0_1_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_1_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_1_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_1_0_0_0_1_1_0, BRANCH_NONE, 10'b0_1_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_1_0_0_0_1_0_0, BRANCH_NONE, 10'b1_1_0_0_1_1_0_0_1_0, PC_EXCEPTION);
    add_fsm(10'b1_1_0_0_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    close_fsm("branch and ecall");
    add_fsm(10'b1_1_0_0_0_1_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_1_0_1_1_0, BRANCH_NONE, 10'b0_1_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b1_1_0_0_0_1_0_1_0_0, BRANCH_NONE, 10'b1_1_0_0_1_0_0_0_0_1, PC_ERET);
    add_fsm(10'b1_1_0_0_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    close_fsm("return from trap");
    // wfi with fetch off, woken by an external request
    add_fsm(10'b0_1_0_0_0_0_1_1_0_0, BRANCH_NONE, 10'b0_1_0_1_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_0_0_1_0_1_0, BRANCH_NONE, 10'b0_1_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_0_0_1_0_0_0, BRANCH_NONE, 10'b0_1_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b0_0_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b0_0_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_1_0_0_0_0_0, BRANCH_NONE, 10'b0_0_0_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_1_0_0_0_0_0, BRANCH_NONE, 10'b0_1_1_0_1_0_0_0_0_0, PC_BOOT);
    add_fsm(10'b0_0_0_0_0_0_0_0_0_0, BRANCH_NONE, 10'b1_1_0_0_0_1_1_1_0_0, PC_EXCEPTION);
    add_fsm(10'b1_1_0_0_0_0_0_1_0_0, BRANCH_NONE, 10'b0_1_0_1_0_0_0_0_0_0, PC_BOOT);
    close_fsm("sleep and wake");

    //       we ex  wb  alu  iv dreq ill mis mult jalr   load jr dropwe
    add_comb(12'b000_000_000_000, 6'b100000, 3'b000, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b010_000_100_000, 6'b100000, 3'b000, SEL_FW_WB, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b011_000_010_010, 6'b100000, 3'b000, SEL_REGFILE, SEL_FW_EX, SEL_REGFILE);
    add_comb(12'b000_000_001_000, 6'b100000, 3'b000, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b011_000_100_010, 6'b100100, 3'b000, SEL_FW_EX, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b010_000_001_000, 6'b100010, 3'b000, SEL_REGFILE, SEL_REGFILE, SEL_FW_EX);
    add_comb(12'b010_000_001_000, 6'b100110, 3'b000, SEL_FW_EX, SEL_REGFILE, SEL_FW_WB);
    add_random(24);
    close_comb("forwarding");
    add_comb(12'b100_010_000_000, 6'b110000, 3'b101, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b000_100_000_000, 6'b110000, 3'b000, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b001_000_000_100, 6'b100001, 3'b011, SEL_FW_EX, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b100_100_000_000, 6'b100001, 3'b011, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b000_000_000_000, 6'b101000, 3'b001, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_comb(12'b000_000_000_000, 6'b000000, 3'b001, SEL_REGFILE, SEL_REGFILE, SEL_REGFILE);
    add_random(24);
    close_comb("hazards");

    total_rows = fsm_q.size() + comb_q.size();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    first = 0;
    for (t = 0; t < fsm_names.size(); t++)
    begin
      errs0 = errors;
      for (i = first; i < fsm_cuts[t]; i++)
        apply_fsm(fsm_q[i]);
      report(fsm_names[t], fsm_cuts[t] - first, errors - errs0);
      first = fsm_cuts[t];
    end
    first = 0;
    for (t = 0; t < comb_names.size(); t++)
    begin
      errs0 = errors;
      for (i = first; i < comb_cuts[t]; i++)
        apply_comb(comb_q[i]);
      report(comb_names[t], comb_cuts[t] - first, errors - errs0);
      first = comb_cuts[t];
    end

    $display("summary: %0d tests, %0d checks, %0d mismatches",
             fsm_names.size() + comb_names.size(), checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
